/* minmax.f */
source/minmax_pkg.sv
source/axil_if.sv
source/stream_if.sv
source/minmax_slv.sv
source/credit_buffer.sv
source/minmax_core.sv
source/minmax_top.sv
tests/clk_gen.sv
tests/minmax_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the min/max finder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module minmax_tb -f minmax.f -o minmax_sim
if [ $? -ne 0 ]; then
  echo "Verilator compilation failed"
  exit 1
fi

output=$(./obj_dir/minmax_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF -- '** PASS **'; then
  exit 0
fi
exit 1

/* tests/minmax_tb.sv */
module minmax_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int WAIT_LIMIT = 200;
  localparam int POLL_LIMIT = 20;
  localparam int MAX_WORDS  = 9;
  localparam int NUM_ROWS   = 8;
  localparam int HOLD_ROW   = 7;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // One frame and its expected results
  typedef struct packed {
    int                                len;
    minmax_pkg::word_t [MAX_WORDS-1:0] words;
    minmax_pkg::word_t                 exp_min;
    minmax_pkg::word_t                 exp_max;
    logic                              exp_stat;
  } frame_row_t;

  logic                                    aclk;
  logic                                    aresetn;
  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr;
  logic                                    s_axil_awvalid;
  logic                                    s_axil_awready;
  logic [minmax_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata;
  logic [minmax_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb;
  logic                                    s_axil_wvalid;
  logic                                    s_axil_wready;
  logic [1:0]                              s_axil_bresp;
  logic                                    s_axil_bvalid;
  logic                                    s_axil_bready;
  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr;
  logic                                    s_axil_arvalid;
  logic                                    s_axil_arready;
  logic [minmax_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata;
  logic [1:0]                              s_axil_rresp;
  logic                                    s_axil_rvalid;
  logic                                    s_axil_rready;
  logic                                    in_valid;
  minmax_pkg::word_t                       in_data;
  logic                                    in_last;
  logic                                    in_credit;

  frame_row_t rows [NUM_ROWS];
  int         credits;
  int         errors;
  int         test_start;
  int         tests_passed;
  int         tests_failed;

  clk_gen #(
    .PERIOD       (100),
    .RESET_CYCLES (8)
  ) u_clk_gen (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  minmax_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_last        (in_last),
    .in_credit      (in_credit)
  );

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_word(input string name, input minmax_pkg::word_t exp,
                            input minmax_pkg::word_t act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    errors++;
  endtask

  // One clock cycle, counting any returned credit
  task automatic next_cycle();
    @(negedge aclk);
    if (in_credit === 1'b1)
      credits++;
  endtask

  // ------------------------------
  // AXI-Lite host
  // ------------------------------
  task automatic axil_write(input minmax_pkg::reg_addr_e idx, input minmax_pkg::word_t data);
    int waited;
    s_axil_awaddr  = {idx, 2'b00};
    s_axil_wdata   = data;
    s_axil_wstrb   = '1;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    waited = 0;
    do
    begin
      next_cycle();
      waited++;
    end while (!(s_axil_awready === 1'b1 && s_axil_wready === 1'b1) && waited < WAIT_LIMIT);
    if (s_axil_awready !== 1'b1 || s_axil_wready !== 1'b1)
    begin
      report_timeout("write address and data never accepted");
      s_axil_awvalid = 1'b0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      return;
    end
    // Ready seen, transfer on the next rising edge
    next_cycle();
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    waited = 0;
    while (s_axil_bvalid !== 1'b1 && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if (s_axil_bvalid !== 1'b1)
      report_timeout("no write response");
    else
      check_resp("bresp", RESP_OKAY, s_axil_bresp);
    next_cycle();
    s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input minmax_pkg::reg_addr_e idx, output minmax_pkg::word_t data);
    int waited;
    data           = 'x;
    s_axil_araddr  = {idx, 2'b00};
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    waited = 0;
    do
    begin
      next_cycle();
      waited++;
    end while (s_axil_arready !== 1'b1 && waited < WAIT_LIMIT);
    if (s_axil_arready !== 1'b1)
    begin
      report_timeout("read address never accepted");
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      return;
    end
    next_cycle();
    s_axil_arvalid = 1'b0;
    waited = 0;
    while (s_axil_rvalid !== 1'b1 && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if (s_axil_rvalid !== 1'b1)
      report_timeout("no read data");
    else
    begin
      data = s_axil_rdata;
      check_resp("rresp", RESP_OKAY, s_axil_rresp);
    end
    next_cycle();
    s_axil_rready = 1'b0;
  endtask

  task automatic poll_done();
    minmax_pkg::word_t stat;
    int                polls;
    stat  = '0;
    polls = 0;
    while (stat[0] !== 1'b1 && polls < POLL_LIMIT)
    begin
      axil_read(minmax_pkg::REG_STAT, stat);
      polls++;
    end
    if (stat[0] !== 1'b1)
      report_timeout("status done bit never set");
  endtask

  // ------------------------------
  // Credited producer
  // ------------------------------
  task automatic send_frame(input int r);
    int i;
    int waited;
    for (i = 0; i < rows[r].len; i++)
    begin
      waited = 0;
      while (credits == 0 && waited < WAIT_LIMIT)
      begin
        next_cycle();
        waited++;
      end
      if (credits == 0)
      begin
        report_timeout("producer never got a credit");
        return;
      end
      in_valid = 1'b1;
      in_data  = rows[r].words[i];
      in_last  = (i == rows[r].len - 1);
      credits--;
      next_cycle();
      in_valid = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic check_row(input int r);
    minmax_pkg::word_t value;
    poll_done();
    axil_read(minmax_pkg::REG_MIN, value);
    check_word("minimum", rows[r].exp_min, value);
    axil_read(minmax_pkg::REG_MAX, value);
    check_word("maximum", rows[r].exp_max, value);
    axil_read(minmax_pkg::REG_STAT, value);
    check_status("done", rows[r].exp_stat, value[0]);
  endtask

  task automatic clear_and_check();
    minmax_pkg::word_t value;
    axil_write(minmax_pkg::REG_CTRL, 32'h1);
    axil_read(minmax_pkg::REG_STAT, value);
    check_status("done", 1'b0, value[0]);
    axil_read(minmax_pkg::REG_MIN, value);
    check_word("minimum", '1, value);
    axil_read(minmax_pkg::REG_MAX, value);
    check_word("maximum", '0, value);
  endtask

  task automatic end_test(input string name);
    if (errors == test_start)
    begin
      tests_passed++;
      $display("Test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - test_start);
    end
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_word(input int r, input minmax_pkg::word_t w);
    rows[r].words[rows[r].len] = w;
    rows[r].len++;
  endtask

  task automatic set_expected(input int r, input minmax_pkg::word_t lo,
                              input minmax_pkg::word_t hi);
    rows[r].exp_min  = lo;
    rows[r].exp_max  = hi;
    rows[r].exp_stat = 1'b1;
  endtask

  // Unsigned extremes of a random row
  task automatic derive_expected(input int r);
    minmax_pkg::word_t lo;
    minmax_pkg::word_t hi;
    int                i;
    lo = rows[r].words[0];
    hi = rows[r].words[0];
    for (i = 1; i < rows[r].len; i++)
    begin
      if (rows[r].words[i] < lo)
        lo = rows[r].words[i];
      if (rows[r].words[i] > hi)
        hi = rows[r].words[i];
    end
    set_expected(r, lo, hi);
  endtask

  task automatic build_table();
    int r;
    int i;
    int n;
    for (r = 0; r < NUM_ROWS; r++)
      rows[r] = '0;
    add_word(0, 32'h0000_0005);
    set_expected(0, 32'h0000_0005, 32'h0000_0005);
    add_word(1, 32'h0000_0003);
    add_word(1, 32'hFFFF_FFFF);
    add_word(1, 32'h0000_0000);
    add_word(1, 32'h0000_0007);
    set_expected(1, 32'h0000_0000, 32'hFFFF_FFFF);
    // Top bit set must count as large
    add_word(2, 32'h8000_0000);
    add_word(2, 32'h7FFF_FFFF);
    add_word(2, 32'h8000_0001);
    set_expected(2, 32'h7FFF_FFFF, 32'h8000_0001);
    add_word(3, 32'h0000_0055);
    add_word(3, 32'h0000_0054);
    add_word(3, 32'h0000_0056);
    add_word(3, 32'h0000_0055);
    set_expected(3, 32'h0000_0054, 32'h0000_0056);
    for (r = 4; r < HOLD_ROW; r++)
    begin
      n = 1 + int'($urandom % MAX_WORDS);
      for (i = 0; i < n; i++)
        add_word(r, $urandom);
      derive_expected(r);
    end
    // Exactly one buffer full for the stall test
    add_word(HOLD_ROW, 32'h0BAD_0001);
    add_word(HOLD_ROW, 32'h0000_0010);
    add_word(HOLD_ROW, 32'hF000_0000);
    add_word(HOLD_ROW, 32'h0000_0011);
    set_expected(HOLD_ROW, 32'h0000_0010, 32'hF000_0000);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    minmax_pkg::word_t value;
    int                r;
    int                k;
    logic              credit_seen;

    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    in_valid       = 1'b0;
    in_data        = '0;
    in_last        = 1'b0;
    credits        = FIFO_DEPTH;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    void'($urandom(11));
    build_table();

    k = 0;
    next_cycle();
    while (aresetn !== 1'b1 && k < WAIT_LIMIT)
    begin
      next_cycle();
      k++;
    end
    if (aresetn !== 1'b1)
      report_timeout("reset never released");

    test_start = errors;
    axil_read(minmax_pkg::REG_STAT, value);
    check_status("done", 1'b0, value[0]);
    axil_read(minmax_pkg::REG_MIN, value);
    check_word("minimum", '1, value);
    axil_read(minmax_pkg::REG_MAX, value);
    check_word("maximum", '0, value);
    axil_read(minmax_pkg::REG_CTRL, value);
    check_word("ctrl readback", '0, value);
    axil_write(minmax_pkg::REG_CTRL, 32'h0);
    end_test("reset values");

    for (r = 0; r < HOLD_ROW; r++)
    begin
      test_start = errors;
      send_frame(r);
      check_row(r);
      clear_and_check();
      end_test($sformatf("frame %0d", r));
    end

    // Stall row goes in while the core holds row 1
    test_start = errors;
    send_frame(1);
    check_row(1);
    send_frame(HOLD_ROW);
    check_count("credits", 0, credits);
    credit_seen = 1'b0;
    for (k = 0; k < 30; k++)
    begin
      next_cycle();
      if (in_credit === 1'b1)
        credit_seen = 1'b1;
    end
    check_status("in_credit", 1'b0, credit_seen);
    check_count("credits", 0, credits);
    axil_write(minmax_pkg::REG_CTRL, 32'h1);
    check_row(HOLD_ROW);
    check_count("credits", FIFO_DEPTH, credits);
    end_test("back-pressure");

    test_start = errors;
    axil_write(minmax_pkg::REG_MIN, 32'h0000_0000);
    axil_write(minmax_pkg::REG_MAX, 32'hFFFF_FFFF);
    axil_read(minmax_pkg::REG_MIN, value);
    check_word("minimum", rows[HOLD_ROW].exp_min, value);
    axil_read(minmax_pkg::REG_MAX, value);
    check_word("maximum", rows[HOLD_ROW].exp_max, value);
    clear_and_check();
    end_test("read-only results");

    $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* tests/clk_gen.sv */
module clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic aclk,
  output logic aresetn
);

  initial
  begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

  // Released just after a rising edge
  initial
  begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    aresetn <= 1'b1;
  end

endmodule

/* source/minmax_top.sv */
module minmax_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                    aclk,
  input  logic                                    aresetn,

  // AXI4-Lite control
  input  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
  input  logic                                    s_axil_awvalid,
  output logic                                    s_axil_awready,
  input  logic [minmax_pkg::AXIL_DATA_BITS-1:0]   s_axil_wdata,
  input  logic [minmax_pkg::AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
  input  logic                                    s_axil_wvalid,
  output logic                                    s_axil_wready,
  output logic [1:0]                              s_axil_bresp,
  output logic                                    s_axil_bvalid,
  input  logic                                    s_axil_bready,
  input  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   s_axil_araddr,
  input  logic                                    s_axil_arvalid,
  output logic                                    s_axil_arready,
  output logic [minmax_pkg::AXIL_DATA_BITS-1:0]   s_axil_rdata,
  output logic [1:0]                              s_axil_rresp,
  output logic                                    s_axil_rvalid,
  input  logic                                    s_axil_rready,

  // Credited word input
  input  logic                                    in_valid,
  input  minmax_pkg::word_t                       in_data,
  input  logic                                    in_last,
  output logic                                    in_credit
);

  axil_if   axil_ctrl ();
  stream_if word_stream ();

  logic              clr;
  logic              done;
  minmax_pkg::word_t minimum;
  minmax_pkg::word_t maximum;

  // Plain ports onto the control bus
  assign axil_ctrl.awaddr  = s_axil_awaddr;
  assign axil_ctrl.awvalid = s_axil_awvalid;
  assign axil_ctrl.wdata   = s_axil_wdata;
  assign axil_ctrl.wstrb   = s_axil_wstrb;
  assign axil_ctrl.wvalid  = s_axil_wvalid;
  assign axil_ctrl.bready  = s_axil_bready;
  assign axil_ctrl.araddr  = s_axil_araddr;
  assign axil_ctrl.arvalid = s_axil_arvalid;
  assign axil_ctrl.rready  = s_axil_rready;
  assign s_axil_awready    = axil_ctrl.awready;
  assign s_axil_wready     = axil_ctrl.wready;
  assign s_axil_bresp      = axil_ctrl.bresp;
  assign s_axil_bvalid     = axil_ctrl.bvalid;
  assign s_axil_arready    = axil_ctrl.arready;
  assign s_axil_rdata      = axil_ctrl.rdata;
  assign s_axil_rresp      = axil_ctrl.rresp;
  assign s_axil_rvalid     = axil_ctrl.rvalid;

  credit_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_buffer (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .in_credit (in_credit),
    .out       (word_stream.source)
  );

  minmax_core u_core (
    .aclk    (aclk),
    .aresetn (aresetn),
    .in      (word_stream.sink),
    .clr     (clr),
    .done    (done),
    .minimum (minimum),
    .maximum (maximum)
  );

  minmax_slv u_slv (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .axi_ctrl (axil_ctrl.slave),
    .clr      (clr),
    .done     (done),
    .minimum  (minimum),
    .maximum  (maximum)
  );

endmodule

/* source/minmax_core.sv */
module minmax_core (
  input  logic              aclk,
  input  logic              aresetn,

  stream_if.sink            in,

  input  logic              clr,
  output logic              done,

  output minmax_pkg::word_t minimum,
  output minmax_pkg::word_t maximum
);

  minmax_pkg::core_state_e state;
  logic                    accept;

  // ------------------------------
  // Stream handshake
  // ------------------------------
  assign in.tready = (state == minmax_pkg::ST_RUN);
  assign accept    = in.tvalid && in.tready;

  // ------------------------------
  // FSM and running extremes
  // ------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state   <= minmax_pkg::ST_RUN;
      minimum <= '1;
      maximum <= '0;
      done    <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (clr)
      begin
        // Restart from empty extremes in any state
        state   <= minmax_pkg::ST_RUN;
        minimum <= '1;
        maximum <= '0;
      end
      else
      begin
        case (state)
          minmax_pkg::ST_RUN:
          begin
            if (accept)
            begin
              if (in.tdata < minimum)
                minimum <= in.tdata;
              if (in.tdata > maximum)
                maximum <= in.tdata;
              if (in.tlast)
              begin
                state <= minmax_pkg::ST_HOLD;
                done  <= 1'b1;
              end
            end
          end
          // Results frozen until clr
          minmax_pkg::ST_HOLD: ;
          default: state <= minmax_pkg::ST_RUN;
        endcase
      end
    end
  end

endmodule

/* source/credit_buffer.sv */
module credit_buffer #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              aclk,
  input  logic              aresetn,

  input  logic              in_valid,
  input  minmax_pkg::word_t in_data,
  input  logic              in_last,
  output logic              in_credit,

  stream_if.source          out
);

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(FIFO_DEPTH - 1);

  // Storage
  minmax_pkg::word_t data_mem [FIFO_DEPTH];
  logic              last_mem [FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  // Credited producer never overfills the FIFO
  always_ff @(posedge aclk)
  begin
    if (in_valid)
    begin
      data_mem[wr_ptr] <= in_data;
      last_mem[wr_ptr] <= in_last;
    end
  end

  assign pop = out.tvalid && out.tready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      count     <= count + CNT_BITS'(in_valid) - CNT_BITS'(pop);
      // One credit back per popped word
      in_credit <= pop;
    end
  end

  // Head of queue
  assign out.tvalid = (count != '0);
  assign out.tdata  = data_mem[rd_ptr];
  assign out.tlast  = last_mem[rd_ptr];

endmodule

/* source/minmax_slv.sv */
module minmax_slv (
  input  logic              aclk,
  input  logic              aresetn,

  axil_if.slave             axi_ctrl,

  output logic              clr,
  input  logic              done,

  input  minmax_pkg::word_t minimum,
  input  minmax_pkg::word_t maximum
);

  // ------------------------------
  // Declarations
  // ------------------------------
  localparam int ADDR_LSB = $clog2(minmax_pkg::AXIL_DATA_BITS / 8);
  localparam int IDX_BITS = minmax_pkg::AXIL_ADDR_BITS - ADDR_LSB;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [minmax_pkg::AXIL_ADDR_BITS-1:0] axi_awaddr;
  logic [minmax_pkg::AXIL_ADDR_BITS-1:0] axi_araddr;
  logic                                  axi_awready;
  logic                                  axi_wready;
  logic                                  axi_bvalid;
  logic                                  axi_arready;
  logic                                  axi_rvalid;
  logic [minmax_pkg::AXIL_DATA_BITS-1:0] axi_rdata;

  logic                  aw_en;
  logic                  slv_reg_wren;
  logic                  slv_reg_rden;
  minmax_pkg::reg_addr_e wr_reg;
  minmax_pkg::reg_addr_e rd_reg;

  // Self-clearing control bit and sticky status
  logic ctrl_clr;
  logic done_sticky;

  assign wr_reg = minmax_pkg::reg_addr_e'(axi_awaddr[ADDR_LSB +: IDX_BITS]);
  assign rd_reg = minmax_pkg::reg_addr_e'(axi_araddr[ADDR_LSB +: IDX_BITS]);

  // ------------------------------
  // Register writes
  // ------------------------------
  assign slv_reg_wren = axi_wready && axi_ctrl.wvalid && axi_awready && axi_ctrl.awvalid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      ctrl_clr    <= 1'b0;
      done_sticky <= 1'b0;
    end
    else
    begin
      ctrl_clr <= 1'b0;
      if (slv_reg_wren)
      begin
        case (wr_reg)
          minmax_pkg::REG_CTRL:
            ctrl_clr <= axi_ctrl.wstrb[0] && axi_ctrl.wdata[0];
          default: ;
        endcase
      end

      // Clear wins over a done in the same cycle
      if (ctrl_clr)
        done_sticky <= 1'b0;
      else if (done)
        done_sticky <= 1'b1;
    end
  end

  assign clr = ctrl_clr;

  // Address phase, one write in flight
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      axi_awready <= 1'b0;
      axi_wready  <= 1'b0;
      aw_en       <= 1'b1;
    end
    else
    begin
      if (!axi_awready && axi_ctrl.awvalid && axi_ctrl.wvalid && aw_en)
      begin
        axi_awready <= 1'b1;
        axi_wready  <= 1'b1;
        aw_en       <= 1'b0;
      end
      else
      begin
        axi_awready <= 1'b0;
        axi_wready  <= 1'b0;
        if (axi_ctrl.bready && axi_bvalid)
          aw_en <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!axi_awready && axi_ctrl.awvalid && axi_ctrl.wvalid && aw_en)
      axi_awaddr <= axi_ctrl.awaddr;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      axi_bvalid <= 1'b0;
    else if (slv_reg_wren && !axi_bvalid)
      axi_bvalid <= 1'b1;
    else if (axi_ctrl.bready && axi_bvalid)
      axi_bvalid <= 1'b0;
  end

  // ------------------------------
  // Register reads
  // ------------------------------
  assign slv_reg_rden = axi_arready && axi_ctrl.arvalid && !axi_rvalid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      axi_arready <= 1'b0;
    else
      axi_arready <= !axi_arready && axi_ctrl.arvalid && !axi_rvalid;
  end

  always_ff @(posedge aclk)
  begin
    if (!axi_arready && axi_ctrl.arvalid)
      axi_araddr <= axi_ctrl.araddr;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      axi_rvalid <= 1'b0;
    else if (slv_reg_rden)
      axi_rvalid <= 1'b1;
    else if (axi_rvalid && axi_ctrl.rready)
      axi_rvalid <= 1'b0;
  end

  // Data held until rready
  always_ff @(posedge aclk)
  begin
    if (slv_reg_rden)
    begin
      axi_rdata <= '0;
      case (rd_reg)
        minmax_pkg::REG_STAT: axi_rdata[0] <= done_sticky;
        minmax_pkg::REG_MIN:  axi_rdata    <= minimum;
        minmax_pkg::REG_MAX:  axi_rdata    <= maximum;
        default: ;
      endcase
    end
  end

  // Outputs
  assign axi_ctrl.awready = axi_awready;
  assign axi_ctrl.wready  = axi_wready;
  assign axi_ctrl.bvalid  = axi_bvalid;
  assign axi_ctrl.bresp   = RESP_OKAY;
  assign axi_ctrl.arready = axi_arready;
  assign axi_ctrl.rvalid  = axi_rvalid;
  assign axi_ctrl.rdata   = axi_rdata;
  assign axi_ctrl.rresp   = RESP_OKAY;

endmodule

/* source/stream_if.sv */
interface stream_if;

  logic              tvalid;
  minmax_pkg::word_t tdata;
  logic              tlast;
  logic              tready;

  // Transfer when tvalid and tready are both high
  modport source (
    output tvalid, tdata, tlast,
    input  tready
  );

  modport sink (
    input  tvalid, tdata, tlast,
    output tready
  );

endinterface

/* source/axil_if.sv */
interface axil_if;

  // Write address and data
  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   awaddr;
  logic                                    awvalid;
  logic                                    awready;
  logic [minmax_pkg::AXIL_DATA_BITS-1:0]   wdata;
  logic [minmax_pkg::AXIL_DATA_BITS/8-1:0] wstrb;
  logic                                    wvalid;
  logic                                    wready;

  // Write response
  logic [1:0]                              bresp;
  logic                                    bvalid;
  logic                                    bready;

  // Read address and data
  logic [minmax_pkg::AXIL_ADDR_BITS-1:0]   araddr;
  logic                                    arvalid;
  logic                                    arready;
  logic [minmax_pkg::AXIL_DATA_BITS-1:0]   rdata;
  logic [1:0]                              rresp;
  logic                                    rvalid;
  logic                                    rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

/* source/minmax_pkg.sv */
package minmax_pkg;

  // ------------------------------
  // Bus and stream widths
  // ------------------------------
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_ADDR_BITS = 4;
  localparam int DATA_BITS      = 32;

  typedef logic [DATA_BITS-1:0] word_t;

  // Register index, byte address divided by four
  typedef enum logic [1:0] {
    REG_CTRL = 2'd0,
    REG_STAT = 2'd1,
    REG_MIN  = 2'd2,
    REG_MAX  = 2'd3
  } reg_addr_e;

  // Core FSM states
  typedef enum logic {
    ST_RUN  = 1'b0,
    ST_HOLD = 1'b1
  } core_state_e;

endpackage
